/* rtl/gfx_macros.svh */
`ifndef GFX_MACROS_SVH
`define GFX_MACROS_SVH

// Bits per color channel.
`define GFX_COLOR_WIDTH 4

// Horizontal mode, in columns counted from 0.
`define GFX_H_VISIBLE 16
`define GFX_H_SYNC_START 18
`define GFX_H_SYNC_END 20
`define GFX_H_LINE_END 23

// Vertical mode, in lines counted from 0.
`define GFX_V_VISIBLE 12
`define GFX_V_SYNC_START 13
`define GFX_V_SYNC_END 14
`define GFX_V_FRAME_END 15

// One entry per visible pixel.
`define GFX_FB_DEPTH (`GFX_H_VISIBLE * `GFX_V_VISIBLE)

`endif

/* rtl/gfx_pkg.sv */
`default_nettype none

`include "gfx_macros.svh"

package gfx_pkg;

  typedef logic [`GFX_COLOR_WIDTH-1:0] color_t;

  typedef struct packed {
    color_t red;
    color_t grn;
    color_t blu;
  } pixel_t;

  typedef logic [$clog2(`GFX_H_LINE_END + 1)-1:0] h_coord_t;  // Spans a full line.
  typedef logic [$clog2(`GFX_V_FRAME_END + 1)-1:0] v_coord_t;  // Spans a full frame.
  typedef logic [$clog2(`GFX_FB_DEPTH)-1:0] fb_addr_t;

endpackage

`default_nettype wire

/* rtl/gfx_pattern.sv */
`timescale 1ns/1ps
`default_nettype none

`include "gfx_macros.svh"

module gfx_pattern
  import gfx_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     fill_start,
  output logic     fill_done,
  output logic     wr_en,
  output fb_addr_t wr_addr,
  output pixel_t   wr_pixel
);

  localparam h_coord_t H_LAST = h_coord_t'(`GFX_H_VISIBLE - 1);
  localparam v_coord_t V_LAST = v_coord_t'(`GFX_V_VISIBLE - 1);
  localparam fb_addr_t FB_DEPTH = fb_addr_t'(`GFX_FB_DEPTH);

  logic     busy;
  h_coord_t col;
  v_coord_t row;
  color_t   seq;  // Fill number, first fill is 1.
  logic     last_pixel;

  assign last_pixel = (col == H_LAST) && (row == V_LAST);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      wr_en     <= 1'b0;
      fill_done <= 1'b0;
      wr_addr   <= '0;
      col       <= '0;
      row       <= '0;
      seq       <= '0;
    end else begin
      fill_done <= 1'b0;
      if (!busy) begin
        if (fill_start) begin
          busy    <= 1'b1;
          wr_en   <= 1'b1;
          wr_addr <= '0;
          col     <= '0;
          row     <= '0;
          seq     <= seq + color_t'(1);
        end
      end else if (last_pixel) begin
        busy      <= 1'b0;
        wr_en     <= 1'b0;
        fill_done <= 1'b1;
      end else begin
        wr_addr <= wr_addr + fb_addr_t'(1);
        if (col == H_LAST) begin
          col <= '0;
          row <= row + v_coord_t'(1);
        end else begin
          col <= col + h_coord_t'(1);
        end
      end
    end
  end

  // Image rule, column and line in red and green, fill number in blue.
  assign wr_pixel.red = color_t'(col);
  assign wr_pixel.grn = color_t'(row);
  assign wr_pixel.blu = seq;

  assert property (@(posedge clk) disable iff (!rst_n) !busy |-> !wr_en);

  assert property (@(posedge clk) disable iff (!rst_n) wr_en |-> wr_addr < FB_DEPTH);

  // An accepted start gives a full run of writes, then one done strobe.
  assert property (@(posedge clk) disable iff (!rst_n)
    fill_start && !busy |=> wr_en [*`GFX_FB_DEPTH] ##1 (fill_done && !wr_en));

endmodule

`default_nettype wire

/* rtl/raster_timing.sv */
`timescale 1ns/1ps
`default_nettype none

`include "gfx_macros.svh"

module raster_timing
  import gfx_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  output h_coord_t scan_x,
  output v_coord_t scan_y,
  output logic     scan_visible,
  output logic     hsync_raw,
  output logic     vsync_raw
);

  localparam h_coord_t H_VISIBLE = h_coord_t'(`GFX_H_VISIBLE);
  localparam h_coord_t H_SYNC_START = h_coord_t'(`GFX_H_SYNC_START);
  localparam h_coord_t H_SYNC_END = h_coord_t'(`GFX_H_SYNC_END);
  localparam h_coord_t H_LINE_END = h_coord_t'(`GFX_H_LINE_END);

  localparam v_coord_t V_VISIBLE = v_coord_t'(`GFX_V_VISIBLE);
  localparam v_coord_t V_SYNC_START = v_coord_t'(`GFX_V_SYNC_START);
  localparam v_coord_t V_SYNC_END = v_coord_t'(`GFX_V_SYNC_END);
  localparam v_coord_t V_FRAME_END = v_coord_t'(`GFX_V_FRAME_END);

  h_coord_t h_cnt;
  h_coord_t h_next;
  v_coord_t v_cnt;
  v_coord_t v_next;

  always_comb begin
    h_next = h_cnt + h_coord_t'(1);
    v_next = v_cnt;
    if (h_cnt == H_LINE_END) begin
      h_next = '0;
      if (v_cnt == V_FRAME_END) begin
        v_next = '0;
      end else begin
        v_next = v_cnt + v_coord_t'(1);
      end
    end
  end

  // Flags are computed from the next position so they line up with the counters.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      h_cnt        <= H_LINE_END;  // Park on the last blank position.
      v_cnt        <= V_FRAME_END;
      scan_visible <= 1'b0;
      hsync_raw    <= 1'b0;
      vsync_raw    <= 1'b0;
    end else begin
      h_cnt        <= h_next;
      v_cnt        <= v_next;
      scan_visible <= (h_next < H_VISIBLE) && (v_next < V_VISIBLE);
      hsync_raw    <= (h_next >= H_SYNC_START) && (h_next < H_SYNC_END);
      vsync_raw    <= (v_next >= V_SYNC_START) && (v_next < V_SYNC_END);
    end
  end

  assign scan_x = h_cnt;
  assign scan_y = v_cnt;

  assert property (@(posedge clk) disable iff (!rst_n)
    (h_cnt <= H_LINE_END) && (v_cnt <= V_FRAME_END));

endmodule

`default_nettype wire

/* rtl/gfx_framebuffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "gfx_macros.svh"

module gfx_framebuffer
  import gfx_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     wr_en,
  input  fb_addr_t wr_addr,
  input  pixel_t   wr_pixel,
  input  h_coord_t scan_x,
  input  v_coord_t scan_y,
  input  logic     scan_visible,
  input  logic     hsync_raw,
  input  logic     vsync_raw,
  output color_t   vga_red,
  output color_t   vga_grn,
  output color_t   vga_blu,
  output logic     vga_hsync,
  output logic     vga_vsync
);

  localparam fb_addr_t LINE_PITCH = fb_addr_t'(`GFX_H_VISIBLE);
  localparam fb_addr_t FB_DEPTH = fb_addr_t'(`GFX_FB_DEPTH);

  pixel_t   mem [`GFX_FB_DEPTH];
  pixel_t   rd_pixel;
  fb_addr_t rd_addr;
  logic     visible_d;

  assign rd_addr = fb_addr_t'(scan_y) * LINE_PITCH + fb_addr_t'(scan_x);

  // Read before write on a shared address.
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_pixel;
    end
    if (scan_visible) begin
      rd_pixel <= mem[rd_addr];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      visible_d <= 1'b0;
      vga_hsync <= 1'b0;
      vga_vsync <= 1'b0;
    end else begin
      visible_d <= scan_visible;  // Same delay as the memory read.
      vga_hsync <= hsync_raw;
      vga_vsync <= vsync_raw;
    end
  end

  assign vga_red = visible_d ? rd_pixel.red : '0;
  assign vga_grn = visible_d ? rd_pixel.grn : '0;
  assign vga_blu = visible_d ? rd_pixel.blu : '0;

  assert property (@(posedge clk) disable iff (!rst_n) scan_visible |-> rd_addr < FB_DEPTH);

endmodule

`default_nettype wire

/* rtl/gfx_pattern_top.sv */
`timescale 1ns/1ps
`default_nettype none

module gfx_pattern_top
  import gfx_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   continuous_write,
  output logic   fill_done,
  output color_t vga_red,
  output color_t vga_grn,
  output color_t vga_blu,
  output logic   vga_hsync,
  output logic   vga_vsync
);

  logic     fill_start;

  logic     wr_en;
  fb_addr_t wr_addr;
  pixel_t   wr_pixel;

  h_coord_t scan_x;
  v_coord_t scan_y;
  logic     scan_visible;
  logic     hsync_raw;
  logic     vsync_raw;

  // Held high through reset, so the first fill starts as reset releases.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fill_start <= 1'b1;
    end else if (continuous_write) begin
      fill_start <= fill_done;  // Restart right after each fill.
    end else begin
      fill_start <= 1'b0;
    end
  end

  gfx_pattern u_pattern (
    .clk       (clk),
    .rst_n     (rst_n),
    .fill_start(fill_start),
    .fill_done (fill_done),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_pixel  (wr_pixel)
  );

  raster_timing u_timing (
    .clk         (clk),
    .rst_n       (rst_n),
    .scan_x      (scan_x),
    .scan_y      (scan_y),
    .scan_visible(scan_visible),
    .hsync_raw   (hsync_raw),
    .vsync_raw   (vsync_raw)
  );

  gfx_framebuffer u_framebuffer (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_pixel    (wr_pixel),
    .scan_x      (scan_x),
    .scan_y      (scan_y),
    .scan_visible(scan_visible),
    .hsync_raw   (hsync_raw),
    .vsync_raw   (vsync_raw),
    .vga_red     (vga_red),
    .vga_grn     (vga_grn),
    .vga_blu     (vga_blu),
    .vga_hsync   (vga_hsync),
    .vga_vsync   (vga_vsync)
  );

endmodule

`default_nettype wire

/* test/tb_gfx_pattern_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "gfx_macros.svh"

module tb_gfx_pattern_top
  import gfx_pkg::*;
();

  localparam logic [31:0] SEED = 32'hed0f_f171;
  localparam int FRAME_CYCLES = (`GFX_H_LINE_END + 1) * (`GFX_V_FRAME_END + 1);
  localparam int DONE_SPACING = `GFX_FB_DEPTH + 2;  // Writes, done cycle, restart cycle.

  localparam h_coord_t H_VISIBLE = h_coord_t'(`GFX_H_VISIBLE);
  localparam h_coord_t H_SYNC_START = h_coord_t'(`GFX_H_SYNC_START);
  localparam h_coord_t H_SYNC_END = h_coord_t'(`GFX_H_SYNC_END);
  localparam h_coord_t H_LINE_END = h_coord_t'(`GFX_H_LINE_END);
  localparam v_coord_t V_VISIBLE = v_coord_t'(`GFX_V_VISIBLE);
  localparam v_coord_t V_SYNC_START = v_coord_t'(`GFX_V_SYNC_START);
  localparam v_coord_t V_SYNC_END = v_coord_t'(`GFX_V_SYNC_END);
  localparam v_coord_t V_FRAME_END = v_coord_t'(`GFX_V_FRAME_END);

  logic   clk = 1'b0;
  logic   rst_n;
  logic   continuous_write;
  logic   fill_done;
  color_t vga_red;
  color_t vga_grn;
  color_t vga_blu;
  logic   vga_hsync;
  logic   vga_vsync;

  logic        hsync_q;
  logic        vsync_q;
  logic        h_lock;
  logic        v_lock;
  logic        locked;
  h_coord_t    trk_x;
  v_coord_t    trk_y;
  logic        exp_hsync;
  logic        exp_vsync;
  logic        exp_visible;
  color_t      exp_red;
  color_t      exp_grn;
  color_t      exp_blu;
  logic [11:0] colors;
  logic [14:0] reset_outputs;
  logic [1:0]  rst_hist = 2'b11;
  logic        prev_cont;
  logic        img_en;
  logic        quiet_en;
  int          fill_cnt;
  int          done_gap;
  int          pix_checked = 0;
  int          n_fills;
  int          reset_errs = 0;
  int          sync_errs = 0;
  int          color_errs = 0;
  int          fill_errs = 0;
  int          run_errs = 0;

  gfx_pattern_top dut (
    .clk             (clk),
    .rst_n           (rst_n),
    .continuous_write(continuous_write),
    .fill_done       (fill_done),
    .vga_red         (vga_red),
    .vga_grn         (vga_grn),
    .vga_blu         (vga_blu),
    .vga_hsync       (vga_hsync),
    .vga_vsync       (vga_vsync)
  );

  always #20 clk = ~clk;

  // Raster position of the current output cycle, recovered from the sync falls.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hsync_q <= 1'b0;
      vsync_q <= 1'b0;
      h_lock  <= 1'b0;
      v_lock  <= 1'b0;
      trk_x   <= '0;
      trk_y   <= '0;
    end else begin
      hsync_q <= vga_hsync;
      vsync_q <= vga_vsync;
      if (hsync_q && !vga_hsync) begin
        trk_x  <= H_SYNC_END + h_coord_t'(1);  // Fall cycle sits on the sync end column.
        h_lock <= 1'b1;
      end else begin
        trk_x <= (trk_x == H_LINE_END) ? '0 : trk_x + h_coord_t'(1);
      end
      if (vsync_q && !vga_vsync) begin
        trk_y  <= V_SYNC_END;  // Still on the first line after the pulse.
        v_lock <= 1'b1;
      end else if (trk_x == H_LINE_END) begin
        trk_y <= (trk_y == V_FRAME_END) ? '0 : trk_y + v_coord_t'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fill_cnt  <= 0;
      done_gap  <= 0;
      prev_cont <= 1'b0;
    end else if (fill_done) begin
      fill_cnt  <= fill_cnt + 1;
      done_gap  <= 1;
      prev_cont <= continuous_write;
    end else begin
      done_gap <= done_gap + 1;
    end
  end

  always_ff @(posedge clk) begin
    rst_hist <= {rst_hist[0], rst_n};
    if (rst_n && img_en && locked && exp_visible) begin
      pix_checked <= pix_checked + 1;
    end
  end

  assign locked        = h_lock && v_lock;
  assign exp_hsync     = (trk_x >= H_SYNC_START) && (trk_x < H_SYNC_END);
  assign exp_vsync     = (trk_y >= V_SYNC_START) && (trk_y < V_SYNC_END);
  assign exp_visible   = (trk_x < H_VISIBLE) && (trk_y < V_VISIBLE);
  assign exp_red       = color_t'(trk_x);
  assign exp_grn       = color_t'(trk_y);
  assign exp_blu       = color_t'(fill_cnt[3:0]);  // Fill number modulo 16.
  assign colors        = {vga_red, vga_grn, vga_blu};
  assign reset_outputs = {fill_done, vga_hsync, vga_vsync, colors};

  assert property (@(posedge clk) (rst_hist != 2'b11) |-> reset_outputs == '0)
    else begin
      reset_errs++;
      $display("ERROR %0t reset_outputs got %0h expected 0", $time, $sampled(reset_outputs));
    end

  assert property (@(posedge clk) disable iff (!rst_n) h_lock |-> vga_hsync == exp_hsync)
    else begin
      sync_errs++;
      $display("ERROR %0t vga_hsync got %0b expected %0b", $time, $sampled(vga_hsync),
               $sampled(exp_hsync));
    end

  assert property (@(posedge clk) disable iff (!rst_n) locked |-> vga_vsync == exp_vsync)
    else begin
      sync_errs++;
      $display("ERROR %0t vga_vsync got %0b expected %0b", $time, $sampled(vga_vsync),
               $sampled(exp_vsync));
    end

  assert property (@(posedge clk) disable iff (!rst_n) locked && !exp_visible |-> colors == '0)
    else begin
      color_errs++;
      $display("ERROR %0t colors got %0h expected 0", $time, $sampled(colors));
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    img_en && locked && exp_visible |-> vga_red == exp_red)
    else begin
      color_errs++;
      $display("ERROR %0t vga_red got %0h expected %0h", $time, $sampled(vga_red),
               $sampled(exp_red));
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    img_en && locked && exp_visible |-> vga_grn == exp_grn)
    else begin
      color_errs++;
      $display("ERROR %0t vga_grn got %0h expected %0h", $time, $sampled(vga_grn),
               $sampled(exp_grn));
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    img_en && locked && exp_visible |-> vga_blu == exp_blu)
    else begin
      color_errs++;
      $display("ERROR %0t vga_blu got %0h expected %0h", $time, $sampled(vga_blu),
               $sampled(exp_blu));
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    fill_done && prev_cont |-> done_gap == DONE_SPACING)
    else begin
      fill_errs++;
      $display("ERROR %0t fill_done spacing got %0d expected %0d", $time, $sampled(done_gap),
               DONE_SPACING);
    end

  assert property (@(posedge clk) disable iff (!rst_n) quiet_en |-> !fill_done)
    else begin
      fill_errs++;
      $display("A fill_done strobe appeared at %0t after the last expected fill", $time);
    end

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic run_cycles(input int count);
    repeat (count) @(negedge clk);
  endtask

  task automatic wait_fill_count(input int target, input int limit);
    int n;
    n = 0;
    while (fill_cnt < target && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (fill_cnt < target) begin
      run_errs++;
      $display("Timed out after %0d cycles waiting for fill number %0d", limit, target);
    end
  endtask

  task automatic wait_frame_start(input int limit);
    int n;
    n = 0;
    while (!(locked && trk_x == '0 && trk_y == '0) && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (!(locked && trk_x == '0 && trk_y == '0)) begin
      run_errs++;
      $display("Timed out after %0d cycles waiting for the start of a frame", limit);
    end
  endtask

  initial begin
    rst_n            = 1'b0;
    continuous_write = 1'b0;
    img_en           = 1'b0;
    quiet_en         = 1'b0;
    void'($urandom(SEED));
    n_fills = 2 + int'($urandom % 32'd4);

    // One fill only, then two frames of the image.
    apply_reset();
    wait_fill_count(1, 2 * DONE_SPACING);
    quiet_en = 1'b1;
    wait_frame_start(2 * FRAME_CYCLES);
    img_en = 1'b1;
    run_cycles(2 * FRAME_CYCLES);
    img_en   = 1'b0;
    quiet_en = 1'b0;

    // Chained fills; the fill in flight when restarts stop is the last one.
    continuous_write = 1'b1;
    apply_reset();
    wait_fill_count(n_fills - 1, n_fills * DONE_SPACING);
    continuous_write = 1'b0;
    wait_fill_count(n_fills, 2 * DONE_SPACING);
    quiet_en = 1'b1;
    wait_frame_start(2 * FRAME_CYCLES);
    img_en = 1'b1;
    run_cycles(FRAME_CYCLES);
    img_en = 1'b0;
    run_cycles(FRAME_CYCLES);
    quiet_en = 1'b0;

    if (pix_checked != 3 * `GFX_FB_DEPTH) begin
      run_errs++;
      $display("Image checks covered %0d pixels instead of %0d", pix_checked,
               3 * `GFX_FB_DEPTH);
    end
    $display("Error counts: reset %0d, sync %0d, color %0d, fill %0d, run %0d (%0d fills)",
             reset_errs, sync_errs, color_errs, fill_errs, run_errs, n_fills);
    if (reset_errs + sync_errs + color_errs + fill_errs + run_errs == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+rtl
rtl/gfx_pkg.sv
rtl/gfx_pattern.sv
rtl/raster_timing.sv
rtl/gfx_framebuffer.sv
rtl/gfx_pattern_top.sv
test/tb_gfx_pattern_top.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the result from the log.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_gfx_pattern_top \
  -o tb_sim > "$LOG" 2>&1 \
  && ./obj_dir/tb_sim >> "$LOG" 2>&1 \
  || echo "Simulation failed" >> "$LOG"

cat "$LOG"

grep -q "Simulation failed" "$LOG" && exit 1
grep -q "Simulation completed successfully" "$LOG" || exit 1
exit 0
